//--- Makefile
TOP := tb_mem_region

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram
  import mem_region_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     en_i,
  input  wire logic     we_i,
  input  wire be_t      be_i,
  input  wire ram_idx_t idx_i,
  input  wire word_t    wdata_i,
  output word_t         rdata_o
);

  word_t mem [RAM_WORDS];

  // Byte-masked write port
  always_ff @(posedge clk)
  begin
    if (en_i && we_i)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (be_i[b])
        begin
          mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Synchronous read, data shows up the cycle after the enable
  always_ff @(posedge clk)
  begin
    if (en_i && !we_i)
    begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

//--- lsu_demux.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_demux
  import mem_region_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  // Core load/store port
  input  wire logic  core_req_i,
  output logic       core_gnt_o,
  output logic       core_rvalid_o,
  input  wire addr_t core_addr_i,
  input  wire logic  core_we_i,
  input  wire be_t   core_be_i,
  input  wire word_t core_wdata_i,
  output word_t      core_rdata_o,

  // Local SRAM path, command fields are taken from the core port directly
  output logic       ram_req_o,
  input  wire logic  ram_gnt_i,
  input  wire logic  ram_rvalid_i,
  input  wire word_t ram_rdata_i,

  // External bus
  output logic       bus_req_o,
  input  wire logic  bus_gnt_i,
  input  wire logic  bus_rvalid_i,
  output addr_t      bus_addr_o,
  output logic       bus_we_o,
  output be_t        bus_be_o,
  output word_t      bus_wdata_o,
  input  wire word_t bus_rdata_i
);

  logic      is_local;
  resp_src_e req_tgt;
  resp_src_e resp_src;
  logic [2:0] outstanding;
  logic [2:0] pending;

  // Page compare on address bits 31:20
  assign is_local = (core_addr_i[ADDR_W-1:PAGE_LSB] == LOCAL_PAGE);
  assign req_tgt  = is_local ? RESP_RAM : RESP_BUS;

  assign ram_req_o = core_req_i &  is_local;
  assign bus_req_o = core_req_i & ~is_local;

  assign bus_addr_o  = core_addr_i;
  assign bus_we_o    = core_we_i;
  assign bus_be_o    = core_be_i;
  assign bus_wdata_o = core_wdata_i;

  assign core_gnt_o = (ram_req_o & ram_gnt_i) | (bus_req_o & bus_gnt_i);

  // Remember where the next response comes from
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_src <= RESP_RAM;
    end
    else if (core_gnt_o)
    begin
      resp_src <= req_tgt;
    end
  end

  // Grants minus responses for the current target
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      outstanding <= '0;
    end
    else
    begin
      case ({core_gnt_o, core_rvalid_o})
        2'b10:   outstanding <= outstanding + 3'd1;
        2'b01:   outstanding <= outstanding - 3'd1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // A response arriving this cycle no longer counts
  assign pending = outstanding - {2'b00, core_rvalid_o};

  assign core_rvalid_o = ram_rvalid_i | bus_rvalid_i;
  assign core_rdata_o  = (resp_src == RESP_BUS) ? bus_rdata_i : ram_rdata_i;

  a_one_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_rvalid_i && bus_rvalid_i))
    else $error("lsu_demux: SRAM and bus responses in the same cycle");

  a_no_switch: assert property (@(posedge clk) disable iff (!rst_n)
    (core_req_i && (req_tgt != resp_src)) |-> (pending == '0))
    else $error("lsu_demux: target switch with responses outstanding");

  // Every response must belong to an earlier grant
  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    core_rvalid_o |-> (outstanding != '0))
    else $error("lsu_demux: response without a pending grant");

endmodule

`default_nettype wire

//--- mem_region_pkg.sv
`default_nettype none

package mem_region_pkg;

  // Bus widths of the load/store path
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Data SRAM geometry, one entry per 32-bit word
  localparam int RAM_IDX_W = 10;
  localparam int RAM_WORDS = 1 << RAM_IDX_W;

  // Page field is address bits 31:20
  localparam int PAGE_LSB = 20;
  localparam logic [ADDR_W-PAGE_LSB-1:0] LOCAL_PAGE = 12'h001;

  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [BE_W-1:0]      be_t;

  // Word index into the SRAM, taken from byte address bits 11:2
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;

  // Target that owes the core its next response
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_BUS = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

//--- mem_region_testdata.txt
# test port we addr be wdata expected_rdata
# port C core, E ext slave, X both at once; hex fields, expected_rdata checked on reads only
1 C 1 00100000 f 11223344 00000000
1 C 1 00100004 f 55667788 00000000
1 C 1 00100008 f deadbeef 00000000
1 C 1 00100ffc f cafef00d 00000000
1 C 0 00100000 f 00000000 11223344
1 C 0 00100004 f 00000000 55667788
1 C 0 00100008 f 00000000 deadbeef
1 C 0 00100ffc f 00000000 cafef00d
2 C 1 00100010 f 00000000 00000000
2 C 1 00100010 1 000000aa 00000000
2 C 1 00100010 4 00bb0000 00000000
2 C 0 00100010 f 00000000 00bb00aa
2 C 1 00100010 a 12345678 00000000
2 C 0 00100010 f 00000000 12bb56aa
2 C 1 00100014 f ffffffff 00000000
2 C 1 00100014 6 00abcd00 00000000
2 C 0 00100014 f 00000000 ffabcdff
2 C 1 00100014 9 11000022 00000000
2 C 0 00100014 f 00000000 11abcd22
2 C 1 00100014 1 ffffff55 00000000
2 C 0 00100014 f 00000000 11abcd55
3 C 0 40000000 f 00000000 e5a50000
3 C 0 40000010 f 00000000 e5a50010
3 C 0 00200000 f 00000000 a5850000
3 C 0 80001230 f 00000000 25a51230
3 C 0 000ffffc f 00000000 a5aafffc
3 C 1 40000020 f 13579bdf 00000000
3 C 0 40000020 f 00000000 13579bdf
3 C 1 40000030 3 0000beef 00000000
3 C 0 40000030 f 00000000 e5a5beef
3 C 1 40000020 c 24680000 00000000
3 C 0 40000020 f 00000000 24689bdf
4 E 1 00100100 f a1b2c3d4 00000000
4 E 1 00100104 f 0badf00d 00000000
4 C 0 00100100 f 00000000 a1b2c3d4
4 C 0 00100104 f 00000000 0badf00d
4 C 1 00100108 f 600dcafe 00000000
4 E 0 00100108 f 00000000 600dcafe
4 E 1 00100108 2 0000ee00 00000000
4 C 0 00100108 f 00000000 600deefe
4 E 0 00100010 f 00000000 12bb56aa
4 E 0 00100014 f 00000000 11abcd55
5 X 1 00100200 f 5a5a5a5a 00000000
5 X 0 00100200 f 00000000 5a5a5a5a
5 X 0 00100004 f 00000000 55667788
5 X 1 00100204 f 89abcdef 00000000
5 X 0 00100204 f 00000000 89abcdef
5 X 0 00100ffc f 00000000 cafef00d
6 C 0 00100000 f 00000000 11223344
6 C 0 40000000 f 00000000 e5a50000
6 C 0 00100004 f 00000000 55667788
6 C 0 40000020 f 00000000 24689bdf
6 E 0 00100008 f 00000000 deadbeef
6 C 0 00100008 f 00000000 deadbeef
6 C 0 00200000 f 00000000 a5850000
6 E 0 00100100 f 00000000 a1b2c3d4
6 C 0 40000030 f 00000000 e5a5beef
7 E 1 00100300 f 01020304 00000000
7 C 1 40000300 f 0a0b0c0d 00000000
7 C 1 00100304 f 10203040 00000000
7 E 0 00100304 f 00000000 10203040
7 C 0 00100300 f 00000000 01020304
7 C 0 40000300 f 00000000 0a0b0c0d
7 X 1 00100300 5 ffeeddcc 00000000
7 X 0 00100300 f 00000000 01ee03cc
7 C 0 40000304 f 00000000 e5a50304

//--- mem_region_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_region_top
  import mem_region_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  // Core load/store port
  input  wire logic  core_req_i,
  output logic       core_gnt_o,
  output logic       core_rvalid_o,
  input  wire addr_t core_addr_i,
  input  wire logic  core_we_i,
  input  wire be_t   core_be_i,
  input  wire word_t core_wdata_i,
  output word_t      core_rdata_o,

  // External bus master port
  output logic       bus_req_o,
  input  wire logic  bus_gnt_i,
  input  wire logic  bus_rvalid_i,
  output addr_t      bus_addr_o,
  output logic       bus_we_o,
  output be_t        bus_be_o,
  output word_t      bus_wdata_o,
  input  wire word_t bus_rdata_i,

  // External slave port into the data SRAM
  input  wire logic  ext_req_i,
  output logic       ext_gnt_o,
  output logic       ext_rvalid_o,
  input  wire addr_t ext_addr_i,
  input  wire logic  ext_we_i,
  input  wire be_t   ext_be_i,
  input  wire word_t ext_wdata_i,
  output word_t      ext_rdata_o
);

  // Core to arbiter, port 1
  logic     core_ram_req;
  logic     core_ram_gnt;
  logic     core_ram_rvalid;
  word_t    core_ram_rdata;

  // Arbiter to SRAM
  logic     ram_en;
  logic     ram_we;
  be_t      ram_be;
  ram_idx_t ram_idx;
  word_t    ram_wdata;
  word_t    ram_rdata;

  lsu_demux u_lsu_demux (
    .clk           ( clk             ),
    .rst_n         ( rst_n           ),
    .core_req_i    ( core_req_i      ),
    .core_gnt_o    ( core_gnt_o      ),
    .core_rvalid_o ( core_rvalid_o   ),
    .core_addr_i   ( core_addr_i     ),
    .core_we_i     ( core_we_i       ),
    .core_be_i     ( core_be_i       ),
    .core_wdata_i  ( core_wdata_i    ),
    .core_rdata_o  ( core_rdata_o    ),
    .ram_req_o     ( core_ram_req    ),
    .ram_gnt_i     ( core_ram_gnt    ),
    .ram_rvalid_i  ( core_ram_rvalid ),
    .ram_rdata_i   ( core_ram_rdata  ),
    .bus_req_o     ( bus_req_o       ),
    .bus_gnt_i     ( bus_gnt_i       ),
    .bus_rvalid_i  ( bus_rvalid_i    ),
    .bus_addr_o    ( bus_addr_o      ),
    .bus_we_o      ( bus_we_o        ),
    .bus_be_o      ( bus_be_o        ),
    .bus_wdata_o   ( bus_wdata_o     ),
    .bus_rdata_i   ( bus_rdata_i     )
  );

  // Byte addresses become word indices, bits 1:0 dropped
  ram_arbiter u_ram_arbiter (
    .clk         ( clk                         ),
    .rst_n       ( rst_n                       ),
    .p0_req_i    ( ext_req_i                   ),
    .p0_gnt_o    ( ext_gnt_o                   ),
    .p0_rvalid_o ( ext_rvalid_o                ),
    .p0_idx_i    ( ext_addr_i[RAM_IDX_W+1:2]   ),
    .p0_we_i     ( ext_we_i                    ),
    .p0_be_i     ( ext_be_i                    ),
    .p0_wdata_i  ( ext_wdata_i                 ),
    .p0_rdata_o  ( ext_rdata_o                 ),
    .p1_req_i    ( core_ram_req                ),
    .p1_gnt_o    ( core_ram_gnt                ),
    .p1_rvalid_o ( core_ram_rvalid             ),
    .p1_idx_i    ( core_addr_i[RAM_IDX_W+1:2]  ),
    .p1_we_i     ( core_we_i                   ),
    .p1_be_i     ( core_be_i                   ),
    .p1_wdata_i  ( core_wdata_i                ),
    .p1_rdata_o  ( core_ram_rdata              ),
    .ram_en_o    ( ram_en                      ),
    .ram_idx_o   ( ram_idx                     ),
    .ram_we_o    ( ram_we                      ),
    .ram_be_o    ( ram_be                      ),
    .ram_wdata_o ( ram_wdata                   ),
    .ram_rdata_i ( ram_rdata                   )
  );

  data_sram u_data_sram (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .we_i    ( ram_we    ),
    .be_i    ( ram_be    ),
    .idx_i   ( ram_idx   ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

//--- ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter
  import mem_region_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,

  // Port 0, external slave, highest priority
  input  wire logic     p0_req_i,
  output logic          p0_gnt_o,
  output logic          p0_rvalid_o,
  input  wire ram_idx_t p0_idx_i,
  input  wire logic     p0_we_i,
  input  wire be_t      p0_be_i,
  input  wire word_t    p0_wdata_i,
  output word_t         p0_rdata_o,

  // Port 1, core path
  input  wire logic     p1_req_i,
  output logic          p1_gnt_o,
  output logic          p1_rvalid_o,
  input  wire ram_idx_t p1_idx_i,
  input  wire logic     p1_we_i,
  input  wire be_t      p1_be_i,
  input  wire word_t    p1_wdata_i,
  output word_t         p1_rdata_o,

  // SRAM side
  output logic          ram_en_o,
  output ram_idx_t      ram_idx_o,
  output logic          ram_we_o,
  output be_t           ram_be_o,
  output word_t         ram_wdata_o,
  input  wire word_t    ram_rdata_i
);

  // Which port was granted in the previous cycle
  logic p0_granted_q;
  logic p1_granted_q;

  // Fixed priority, port 0 never waits
  assign p0_gnt_o = p0_req_i;
  assign p1_gnt_o = p1_req_i & ~p0_req_i;

  assign ram_en_o = p0_req_i | p1_req_i;

  always_comb
  begin
    if (p0_req_i)
    begin
      ram_idx_o   = p0_idx_i;
      ram_we_o    = p0_we_i;
      ram_be_o    = p0_be_i;
      ram_wdata_o = p0_wdata_i;
    end
    else
    begin
      ram_idx_o   = p1_idx_i;
      ram_we_o    = p1_we_i;
      ram_be_o    = p1_be_i;
      ram_wdata_o = p1_wdata_i;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      p0_granted_q <= 1'b0;
      p1_granted_q <= 1'b0;
    end
    else
    begin
      p0_granted_q <= p0_gnt_o;
      p1_granted_q <= p1_gnt_o;
    end
  end

  // One response per grant, one cycle later
  assign p0_rvalid_o = p0_granted_q;
  assign p1_rvalid_o = p1_granted_q;

  // Read data only goes to the port that owns the response
  assign p0_rdata_o = p0_granted_q ? ram_rdata_i : '0;
  assign p1_rdata_o = p1_granted_q ? ram_rdata_i : '0;

  // A core request held off by port 0 keeps its command until granted
  a_p1_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (p1_req_i && !p1_gnt_o) |=>
      (p1_req_i && $stable(p1_idx_i) && $stable(p1_we_i) &&
       $stable(p1_be_i) && $stable(p1_wdata_i)))
    else $error("ram_arbiter: port 1 request dropped or changed while waiting");

endmodule

`default_nettype wire

//--- tb_mem_region.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_region
  import mem_region_pkg::*;
();

  localparam int HALF_PERIOD = 20;
  localparam int MAX_OPS     = 256;

  logic  clk = 1'b0;
  logic  rst_n;

  logic  core_req_i;
  logic  core_gnt_o;
  logic  core_rvalid_o;
  addr_t core_addr_i;
  logic  core_we_i;
  be_t   core_be_i;
  word_t core_wdata_i;
  word_t core_rdata_o;

  logic  bus_req_o;
  logic  bus_gnt_i;
  logic  bus_rvalid_i;
  addr_t bus_addr_o;
  logic  bus_we_o;
  be_t   bus_be_o;
  word_t bus_wdata_o;
  word_t bus_rdata_i;

  logic  ext_req_i;
  logic  ext_gnt_o;
  logic  ext_rvalid_o;
  addr_t ext_addr_i;
  logic  ext_we_i;
  be_t   ext_be_i;
  word_t ext_wdata_i;
  word_t ext_rdata_o;

  // Operations from the data file
  int    op_test [MAX_OPS];
  byte   op_port [MAX_OPS];
  bit    op_we   [MAX_OPS];
  addr_t op_addr [MAX_OPS];
  be_t   op_be   [MAX_OPS];
  word_t op_wdata[MAX_OPS];
  word_t op_exp  [MAX_OPS];
  int    n_ops = 0;
  bit    ops_loaded = 1'b0;

  int test_ops = 0;
  int test_errs = 0;
  int total_errs = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  // Bus model keeps its own error count, folded in per test
  int bus_errs = 0;
  int bus_errs_seen = 0;

  logic [31:0] lfsr_q = 32'h1586;
  word_t bus_mem [addr_t];

  mem_region_top u_mem_region_top (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .core_req_i    ( core_req_i    ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_addr_i   ( core_addr_i   ),
    .core_we_i     ( core_we_i     ),
    .core_be_i     ( core_be_i     ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_rdata_o  ( core_rdata_o  ),
    .bus_req_o     ( bus_req_o     ),
    .bus_gnt_i     ( bus_gnt_i     ),
    .bus_rvalid_i  ( bus_rvalid_i  ),
    .bus_addr_o    ( bus_addr_o    ),
    .bus_we_o      ( bus_we_o      ),
    .bus_be_o      ( bus_be_o      ),
    .bus_wdata_o   ( bus_wdata_o   ),
    .bus_rdata_i   ( bus_rdata_i   ),
    .ext_req_i     ( ext_req_i     ),
    .ext_gnt_o     ( ext_gnt_o     ),
    .ext_rvalid_o  ( ext_rvalid_o  ),
    .ext_addr_i    ( ext_addr_i    ),
    .ext_we_i      ( ext_we_i      ),
    .ext_be_i      ( ext_be_i      ),
    .ext_wdata_i   ( ext_wdata_i   ),
    .ext_rdata_o   ( ext_rdata_o   )
  );

  always #HALF_PERIOD clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic bit next_rand_bit();
    bit fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Two random bits give 0 to 3 cycles
  function automatic int rand_delay();
    int d;
    d = int'(next_rand_bit());
    d = d * 2 + int'(next_rand_bit());
    return d;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t r;
    r = old_w;
    for (int b = 0; b < BE_W; b++)
    begin
      if (be[b])
      begin
        r[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic count_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
    else
    begin
      $display("mismatch %s: expected %08h, got %08h", name, expected, actual);
      count_error();
    end
  endtask

  task automatic check_bus_field(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
    else
    begin
      $display("mismatch %s: expected %08h, got %08h", name, expected, actual);
      bus_errs++;
    end
  endtask

  // Lines starting with # are comments
  task automatic load_ops();
    int    fd;
    int    n;
    int    tn;
    int    we;
    byte   pc;
    addr_t ad;
    be_t   be;
    word_t wd;
    word_t ex;
    string line;
    fd = $fopen("mem_region_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open mem_region_testdata.txt");
      count_error();
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%d %c %h %h %h %h %h", tn, pc, we, ad, be, wd, ex);
          if (n == 7 && n_ops < MAX_OPS)
          begin
            op_test[n_ops]  = tn;
            op_port[n_ops]  = pc;
            op_we[n_ops]    = (we != 0);
            op_addr[n_ops]  = ad;
            op_be[n_ops]    = be;
            op_wdata[n_ops] = wd;
            op_exp[n_ops]   = ex;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One operation on the core port, the ext port or both, until every rvalid is in.
  // Outputs are sampled 1 ns before the rising edge.
  task automatic run_op(input int i);
    bit c_req;
    bit e_req;
    bit c_pend;
    bit e_pend;
    bit c_local;
    int cyc;
    int c_gcyc;
    int e_gcyc;
    c_local = (op_addr[i][ADDR_W-1:PAGE_LSB] == LOCAL_PAGE);
    c_req   = (op_port[i] == "C") || (op_port[i] == "X");
    e_req   = (op_port[i] == "E") || (op_port[i] == "X");
    c_pend  = 1'b0;
    e_pend  = 1'b0;
    cyc     = 0;
    c_gcyc  = 0;
    e_gcyc  = 0;
    @(negedge clk);
    core_req_i   = c_req;
    core_addr_i  = op_addr[i];
    core_we_i    = op_we[i];
    core_be_i    = op_be[i];
    core_wdata_i = op_wdata[i];
    ext_req_i    = e_req;
    ext_addr_i   = op_addr[i];
    ext_we_i     = op_we[i];
    ext_be_i     = op_be[i];
    ext_wdata_i  = op_wdata[i];
    forever
    begin
      #(HALF_PERIOD - 1);
      if (op_port[i] == "X" && cyc == 0)
      begin
        assert (ext_gnt_o && !core_gnt_o)
        else
        begin
          $display("test %0d: ext port did not win the shared SRAM cycle", op_test[i]);
          count_error();
        end
      end
      // Responses to grants of earlier cycles
      if (!c_pend)
      begin
        assert (!core_rvalid_o)
        else
        begin
          $display("test %0d: core_rvalid_o without a pending core grant", op_test[i]);
          count_error();
        end
      end
      else if (core_rvalid_o || (c_local && cyc > c_gcyc))
      begin
        assert (core_rvalid_o)
        else
        begin
          $display("test %0d: no core response one cycle after a local grant", op_test[i]);
          count_error();
        end
        if (core_rvalid_o && !op_we[i])
        begin
          check_value("core_rdata_o", op_exp[i], core_rdata_o);
        end
        c_pend = 1'b0;
      end
      if (!e_pend)
      begin
        assert (!ext_rvalid_o)
        else
        begin
          $display("test %0d: ext_rvalid_o without a pending ext grant", op_test[i]);
          count_error();
        end
      end
      else if (cyc > e_gcyc)
      begin
        assert (ext_rvalid_o)
        else
        begin
          $display("test %0d: no ext response one cycle after its grant", op_test[i]);
          count_error();
        end
        if (ext_rvalid_o && !op_we[i])
        begin
          check_value("ext_rdata_o", op_exp[i], ext_rdata_o);
        end
        e_pend = 1'b0;
      end
      // Grants taken at the coming edge
      if (c_req && core_gnt_o)
      begin
        c_req  = 1'b0;
        c_pend = 1'b1;
        c_gcyc = cyc;
      end
      if (e_req)
      begin
        assert (ext_gnt_o)
        else
        begin
          $display("test %0d: ext_gnt_o low while the ext port requests", op_test[i]);
          count_error();
        end
        e_req  = 1'b0;
        e_pend = 1'b1;
        e_gcyc = cyc;
      end
      if (!c_req && !c_pend && !e_req && !e_pend)
      begin
        break;
      end
      @(negedge clk);
      core_req_i = c_req;
      ext_req_i  = e_req;
      cyc++;
    end
  endtask

  task automatic finish_test(input int tn);
    int new_bus;
    new_bus = bus_errs - bus_errs_seen;
    bus_errs_seen = bus_errs;
    test_errs  += new_bus;
    total_errs += new_bus;
    $display("test %0d: %0d ops, %0d errors", tn, test_ops, test_errs);
    if (test_errs == 0)
    begin
      tests_ok++;
    end
    else
    begin
      tests_bad++;
    end
    test_errs = 0;
    test_ops  = 0;
  endtask

  // External bus slave: random grant and response delays, word memory behind it
  initial
  begin : bus_model
    int    state;
    int    gnt_wait;
    int    rv_wait;
    addr_t waddr;
    word_t cur;
    word_t resp_data;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    state        = 0;
    gnt_wait     = 0;
    rv_wait      = 0;
    resp_data    = '0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      bus_gnt_i    = (state == 1) && (gnt_wait == 0);
      bus_rvalid_i = (state == 2) && (rv_wait == 0);
      bus_rdata_i  = bus_rvalid_i ? resp_data : '0;
      #(HALF_PERIOD - 1);
      if (state == 0 && bus_req_o)
      begin
        check_bus_field("bus_addr_o", core_addr_i, bus_addr_o);
        check_bus_field("bus_we_o", word_t'(core_we_i), word_t'(bus_we_o));
        check_bus_field("bus_be_o", word_t'(core_be_i), word_t'(bus_be_o));
        check_bus_field("bus_wdata_o", core_wdata_i, bus_wdata_o);
        gnt_wait = rand_delay();
        state    = 1;
      end
      else if (state == 1)
      begin
        if (bus_gnt_i)
        begin
          waddr = {bus_addr_o[ADDR_W-1:2], 2'b00};
          cur   = bus_mem.exists(waddr) ? bus_mem[waddr] : (waddr ^ 32'hA5A5_0000);
          if (bus_we_o)
          begin
            bus_mem[waddr] = merge_bytes(cur, bus_wdata_o, bus_be_o);
          end
          resp_data = cur;
          rv_wait   = rand_delay();
          state     = 2;
        end
        else
        begin
          gnt_wait--;
        end
      end
      else if (state == 2)
      begin
        if (bus_rvalid_i)
        begin
          state = 0;
        end
        else
        begin
          rv_wait--;
        end
      end
    end
  end

  initial
  begin : watchdog
    wait (ops_loaded);
    repeat (n_ops * 16 + 100) @(posedge clk);
    $display("timeout: operations did not complete within %0d clock periods", n_ops * 16 + 100);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin : main
    int i;
    rst_n        = 1'b0;
    core_req_i   = 1'b0;
    core_addr_i  = '0;
    core_we_i    = 1'b0;
    core_be_i    = '0;
    core_wdata_i = '0;
    ext_req_i    = 1'b0;
    ext_addr_i   = '0;
    ext_we_i     = 1'b0;
    ext_be_i     = '0;
    ext_wdata_i  = '0;
    load_ops();
    ops_loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < n_ops; i++)
    begin
      if (i > 0 && op_test[i] != op_test[i-1])
      begin
        finish_test(op_test[i-1]);
      end
      test_ops++;
      run_op(i);
    end
    if (n_ops > 0)
    begin
      finish_test(op_test[n_ops-1]);
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_ok, tests_bad, total_errs);
    if (tests_bad == 0 && total_errs == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
mem_region_pkg.sv
data_sram.sv
ram_arbiter.sv
lsu_demux.sv
mem_region_top.sv
tb_mem_region.sv
